/* tb.f */
+incdir+verilog
verilog/arrayPkg.sv
verilog/actionDecode.sv
verilog/arrayStore.sv
verilog/arraySearch.sv
verilog/resultSelect.sv
verilog/arrayMemory.sv
verif/arrayMemory_properties.sv
verif/arrayMemoryTb.sv

/* Makefile */
SIM       := verilator
TOP       := arrayMemoryTb
FILELIST  := tb.f
LINTFLAGS := --lint-only --timing
SIMFLAGS  := --binary --timing --assert -Wno-fatal
BUILDDIR  := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	@status=0; ./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1 || status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILDDIR) $(LOG)

/* verif/arrayMemoryTb.sv */
`timescale 1ns/100ps
`include "arrayMemory_defines.svh"

module arrayMemoryTb import arrayPkg::*; ();

  localparam int CLOCK_PERIOD     = 20;
  localparam int RESET_CYCLES     = 16;
  localparam int PLANNED_REQUESTS = 300;                 // Upper bound on requests below
  localparam int MARGIN_CYCLES    = 50;
  localparam int SEED             = 51725;

  logic                    clock;
  logic                    rstN;
  arrayAction_t            action;
  logic [`ARRAY_BITS-1:0]  array;
  logic [`INDEX_BITS-1:0]  index;
  logic [`DATA_BITS-1:0]   in;
  logic [`DATA_BITS-1:0]   out;

  // Reference model state
  logic [`DATA_BITS-1:0]   modelMem [`ARRAY_COUNT][`INDEX_MAX];
  int                      modelSize [`ARRAY_COUNT];
  int                      modelLongArray;
  int                      modelLongIndex;
  logic [`DATA_BITS-1:0]   modelOut;

  logic [`DATA_BITS-1:0]   expQueue [$];                 // Expected out per request
  string                   noteQueue [$];
  int                      issuedCount = 0;
  int                      checksDone  = 0;
  int                      checkCount  = 0;
  int                      errorCount  = 0;

  arrayMemory u_arrayMemory (
    .clock  (clock),
    .rstN   (rstN),
    .action (action),
    .array  (array),
    .index  (index),
    .in     (in),
    .out    (out)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  // Updates the model state in place and returns the expected out
  function automatic logic [`DATA_BITS-1:0] refApply(arrayAction_t act, int arr, int idx,
                                                    logic [`DATA_BITS-1:0] value);
    logic [`DATA_BITS-1:0] snap [`ARRAY_COUNT][`INDEX_MAX];
    int                    count;

    count = 0;
    case (act)
      actReset: begin
        for (int a = 0; a < `ARRAY_COUNT; a++) begin
          modelSize[a] = 0;
        end
      end
      actWrite: begin
        modelMem[arr][idx] = value;
        if (idx + 1 > modelSize[arr]) begin
          modelSize[arr] = idx + 1;
        end
        modelOut = value;
      end
      actRead: modelOut = modelMem[arr][idx];
      actSize: modelOut = `DATA_BITS'(modelSize[arr]);
      actInc: begin
        if (modelSize[arr] < `INDEX_MAX) begin
          modelSize[arr]++;
        end
      end
      actDec: begin
        if (modelSize[arr] > 0) begin
          modelSize[arr]--;
        end
      end
      actIndex, actLess, actGreater: begin
        for (int pos = 0; pos < modelSize[arr]; pos++) begin
          if (act == actIndex && modelMem[arr][pos] == value) begin
            count = pos + 1;                             // Last hit wins
          end else if (act == actLess && modelMem[arr][pos] < value) begin
            count++;
          end else if (act == actGreater && modelMem[arr][pos] > value) begin
            count++;
          end
        end
        modelOut = `DATA_BITS'(count);
      end
      actUp: begin
        for (int pos = `INDEX_MAX - 1; pos > idx; pos--) begin
          if (pos <= modelSize[arr]) begin
            modelMem[arr][pos] = modelMem[arr][pos - 1];
          end
        end
        modelMem[arr][idx] = value;
        if (modelSize[arr] < `INDEX_MAX) begin
          modelSize[arr]++;
        end
      end
      actLong1: begin
        modelLongArray = arr;
        modelLongIndex = idx;
      end
      actLong2: begin
        snap = modelMem;                                 // Copy reads the old contents
        while (count < int'(value) && idx + count < `INDEX_MAX
               && modelLongIndex + count < `INDEX_MAX) begin
          modelMem[arr][idx + count] = snap[modelLongArray][modelLongIndex + count];
          if (idx + count + 1 > modelSize[arr]) begin
            modelSize[arr] = idx + count + 1;
          end
          count++;
        end
      end
      actPush: begin
        if (modelSize[arr] < `INDEX_MAX) begin
          modelMem[arr][modelSize[arr]] = value;
          modelSize[arr]++;
        end
      end
      actPop: begin
        if (modelSize[arr] > 0) begin
          modelSize[arr]--;
          modelOut = modelMem[arr][modelSize[arr]];
        end
      end
      default: ;                                         // Idle, down and dump
    endcase
    return modelOut;
  endfunction

  task automatic checkValue(logic [`DATA_BITS-1:0] actual, logic [`DATA_BITS-1:0] expected,
                            string what);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("[ERROR] %0t ns: %s gave out %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // One request per falling edge
  task automatic issue(arrayAction_t act, int arr, int idx, logic [`DATA_BITS-1:0] value);
    @(negedge clock);
    action = act;
    array  = `ARRAY_BITS'(arr);
    index  = `INDEX_BITS'(idx);
    in     = value;
    expQueue.push_back(refApply(act, arr, idx, value));
    noteQueue.push_back($sformatf("%s array %0d index %0d in %0h", act.name(), arr, idx, value));
    issuedCount++;
  endtask

  task automatic readRow(int arr);
    for (int i = 0; i < `INDEX_MAX; i++) begin
      issue(actRead, arr, i, '0);
    end
    issue(actSize, arr, 0, '0);
  endtask

  // Two edge latency from sampling to out
  initial begin
    logic [`DATA_BITS-1:0] stageExp [2];
    string                 stageNote [2];
    bit                    stageValid [2];

    stageValid[0] = 1'b0;
    stageValid[1] = 1'b0;
    forever begin
      @(posedge clock);
      stageExp[1]   = stageExp[0];
      stageNote[1]  = stageNote[0];
      stageValid[1] = stageValid[0];
      stageValid[0] = (expQueue.size() > 0);
      if (stageValid[0]) begin
        stageExp[0]  = expQueue.pop_front();
        stageNote[0] = noteQueue.pop_front();
      end
      @(negedge clock);
      if (stageValid[1]) begin
        checkValue(out, stageExp[1], stageNote[1]);
        checksDone++;
      end
    end
  end

  initial begin
    #(CLOCK_PERIOD * (RESET_CYCLES + PLANNED_REQUESTS + MARGIN_CYCLES));
    $display("Timeout: the run did not finish within the expected number of cycles");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    logic [`DATA_BITS-1:0] probe;

    void'($urandom(SEED));
    action = actNone;
    array  = '0;
    index  = '0;
    in     = '0;
    rstN   = 1'b0;
    for (int a = 0; a < `ARRAY_COUNT; a++) begin
      modelSize[a] = 0;
      for (int i = 0; i < `INDEX_MAX; i++) begin
        modelMem[a][i] = '0;
      end
    end
    modelLongArray = 0;
    modelLongIndex = 0;
    modelOut       = '0;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    rstN = 1'b1;

    // Sizes after reset, then write, read and size
    for (int a = 0; a < `ARRAY_COUNT; a++) begin
      issue(actSize, a, 0, '0);
    end
    issue(actWrite, 0, 3, 16'hA5A5);
    issue(actRead, 0, 3, '0);                            // Straight after the write
    issue(actSize, 0, 0, '0);
    issue(actWrite, 0, 1, 16'h1234);
    issue(actRead, 0, 1, '0);
    issue(actSize, 0, 0, '0);
    issue(actWrite, 1, 0, 16'h0F0F);
    issue(actSize, 1, 0, '0);

    // Push past full, pop past empty
    for (int i = 0; i <= `INDEX_MAX; i++) begin
      issue(actPush, 2, 0, `DATA_BITS'(16'h2000 + i));
    end
    issue(actSize, 2, 0, '0);
    for (int i = 0; i <= `INDEX_MAX; i++) begin
      issue(actPop, 2, 0, '0);
    end
    for (int i = 0; i <= `INDEX_MAX; i++) begin
      issue(actInc, 3, 0, '0);
      issue(actSize, 3, 0, '0);
    end
    for (int i = 0; i <= `INDEX_MAX; i++) begin
      issue(actDec, 3, 0, '0);
      issue(actSize, 3, 0, '0);
    end

    // Random fills and scans with small values so matches repeat
    for (int i = 0; i < `INDEX_MAX; i++) begin
      issue(actWrite, 0, i, `DATA_BITS'($urandom % 8));
    end
    for (int i = 0; i < 5; i++) begin
      issue(actWrite, 1, i, `DATA_BITS'($urandom % 8));
    end
    for (int a = 0; a < 2; a++) begin
      for (int p = 0; p < 8; p++) begin
        probe = `DATA_BITS'($urandom % 9);
        issue(actIndex, a, 0, probe);
        issue(actLess, a, 0, probe);
        issue(actGreater, a, 0, probe);
      end
    end

    // Insert in the middle, at the end and into a full array
    issue(actUp, 1, 2, 16'h0100);
    issue(actUp, 1, 6, 16'h0101);
    issue(actUp, 1, 3, 16'h0102);
    issue(actUp, 1, 0, 16'h0103);                        // Top element drops from the full row
    readRow(1);

    // Long moves between arrays and inside one array
    issue(actLong1, 0, 2, '0);
    issue(actLong2, 3, 0, 16'd4);
    for (int i = 0; i < 4; i++) begin
      issue(actRead, 3, i, '0);                          // Only the copied part holds data
    end
    issue(actSize, 3, 0, '0);
    issue(actLong1, 0, 5, '0);
    issue(actLong2, 2, 4, 16'd6);                        // Source end stops the copy
    readRow(2);
    issue(actLong1, 1, 1, '0);
    issue(actLong2, 1, 3, 16'd9);                        // Overlap up with the target end stopping
    readRow(1);
    issue(actLong1, 1, 4, '0);
    issue(actLong2, 1, 2, 16'd3);
    readRow(1);

    // Reset action mid run leaves contents readable
    issue(actReset, 0, 0, '0);
    for (int a = 0; a < `ARRAY_COUNT; a++) begin
      issue(actSize, a, 0, '0);
    end
    readRow(1);
    issue(actDown, 1, 0, 16'h5555);
    issue(actDump, 1, 0, 16'h6666);
    issue(actSize, 1, 0, '0);
    issue(actPush, 1, 0, 16'h7777);
    issue(actRead, 1, 0, '0);
    issue(actPop, 1, 0, '0);
    issue(actPop, 1, 0, '0);

    repeat (3) begin
      issue(actNone, 0, 0, '0);
    end
    wait (checksDone == issuedCount);
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* verif/arrayMemory_properties.sv */
`timescale 1ns/100ps
`include "arrayMemory_defines.svh"

module arrayMemory_properties import arrayPkg::*; (
  input  logic                    clock,
  input  logic                    rstN,
  input  arrayAction_t            opCode,
  input  logic [`SIZE_BITS-1:0]   rowSize,
  input  logic                    popHit,
  input  logic [`DATA_BITS-1:0]   out
);

  logic noResult;                                        // Action leaves out alone

  assign noResult = (opCode inside {actNone, actReset, actInc, actDec, actUp,
                                    actLong1, actLong2, actPush})
                 || (opCode == actPop && !popHit);

  property outClearAfterReset;
    @(posedge clock) !rstN |=> (out == '0);
  endproperty

  property sizeInRange;
    @(posedge clock) disable iff (!rstN) rowSize <= `INDEX_MAX;
  endproperty

  property outHeld;
    @(posedge clock) disable iff (!rstN) noResult |=> $stable(out);
  endproperty

  assert property (outClearAfterReset) else $error("out is not zero after reset");
  assert property (sizeInRange) else $error("rowSize is larger than the array");
  assert property (outHeld) else $error("out changed after an action with no result");

endmodule

bind resultSelect arrayMemory_properties u_arrayMemoryProperties (
  .clock   (clock),
  .rstN    (rstN),
  .opCode  (opCode),
  .rowSize (rowSize),
  .popHit  (popHit),
  .out     (out)
);

/* verilog/arrayMemory.sv */
`timescale 1ns/100ps
`include "arrayMemory_defines.svh"

module arrayMemory import arrayPkg::*; (
  input  logic                    clock,
  input  logic                    rstN,
  input  arrayAction_t            action,
  input  logic [`ARRAY_BITS-1:0]  array,
  input  logic [`INDEX_BITS-1:0]  index,
  input  logic [`DATA_BITS-1:0]   in,
  output logic [`DATA_BITS-1:0]   out
);

  arrayAction_t           opCode;                     // Registered request
  logic [`ARRAY_BITS-1:0] opArray;
  logic [`INDEX_BITS-1:0] opIndex;
  logic [`DATA_BITS-1:0]  opIn;
  logic [`ARRAY_BITS-1:0] longArray;                  // Long move source
  logic [`INDEX_BITS-1:0] longIndex;
  logic [`ROW_BITS-1:0]   rowData;                    // Row of opArray
  logic [`SIZE_BITS-1:0]  rowSize;
  logic                   popHit;
  logic [`SIZE_BITS-1:0]  matchPos;                   // Search results
  logic [`SIZE_BITS-1:0]  lessCount;
  logic [`SIZE_BITS-1:0]  greaterCount;

  actionDecode u_actionDecode (
    .clock     (clock),
    .rstN      (rstN),
    .action    (action),
    .array     (array),
    .index     (index),
    .in        (in),
    .opCode    (opCode),
    .opArray   (opArray),
    .opIndex   (opIndex),
    .opIn      (opIn),
    .longArray (longArray),
    .longIndex (longIndex)
  );

  arrayStore u_arrayStore (
    .clock     (clock),
    .rstN      (rstN),
    .opCode    (opCode),
    .opArray   (opArray),
    .opIndex   (opIndex),
    .opIn      (opIn),
    .longArray (longArray),
    .longIndex (longIndex),
    .rowData   (rowData),
    .rowSize   (rowSize),
    .popHit    (popHit)
  );

  arraySearch u_arraySearch (
    .rowData      (rowData),
    .rowSize      (rowSize),
    .opIn         (opIn),
    .matchPos     (matchPos),
    .lessCount    (lessCount),
    .greaterCount (greaterCount)
  );

  resultSelect u_resultSelect (
    .clock        (clock),
    .rstN         (rstN),
    .opCode       (opCode),
    .opIn         (opIn),
    .opIndex      (opIndex),
    .rowData      (rowData),
    .rowSize      (rowSize),
    .popHit       (popHit),
    .matchPos     (matchPos),
    .lessCount    (lessCount),
    .greaterCount (greaterCount),
    .out          (out)
  );

endmodule

/* verilog/resultSelect.sv */
`timescale 1ns/100ps
`include "arrayMemory_defines.svh"

module resultSelect import arrayPkg::*; (
  input  logic                    clock,
  input  logic                    rstN,
  input  arrayAction_t            opCode,
  input  logic [`DATA_BITS-1:0]   opIn,
  input  logic [`INDEX_BITS-1:0]  opIndex,
  input  logic [`ROW_BITS-1:0]    rowData,
  input  logic [`SIZE_BITS-1:0]   rowSize,
  input  logic                    popHit,
  input  logic [`SIZE_BITS-1:0]   matchPos,
  input  logic [`SIZE_BITS-1:0]   lessCount,
  input  logic [`SIZE_BITS-1:0]   greaterCount,
  output logic [`DATA_BITS-1:0]   out
);

  logic [`INDEX_BITS-1:0] popIndex;
  logic [`DATA_BITS-1:0]  readWord;
  logic [`DATA_BITS-1:0]  popWord;

  assign popIndex = rowSize[`INDEX_BITS-1:0] - 1'b1;   // Wraps correctly for a full row
  assign readWord = rowData[opIndex*`DATA_BITS +: `DATA_BITS];
  assign popWord  = rowData[popIndex*`DATA_BITS +: `DATA_BITS];

  always_ff @(posedge clock) begin
    if (!rstN) begin
      out <= '0;
    end else begin
      case (opCode)
        actWrite:   out <= opIn;
        actRead:    out <= readWord;
        actSize:    out <= `DATA_BITS'(rowSize);
        actIndex:   out <= `DATA_BITS'(matchPos);
        actLess:    out <= `DATA_BITS'(lessCount);
        actGreater: out <= `DATA_BITS'(greaterCount);
        actPop: begin
          if (popHit) begin
            out <= popWord;                           // Empty pop holds out
          end
        end
        default: ;                                    // No result, hold
      endcase
    end
  end

endmodule

/* verilog/arraySearch.sv */
`timescale 1ns/100ps
`include "arrayMemory_defines.svh"

module arraySearch (
  input  logic [`ROW_BITS-1:0]   rowData,
  input  logic [`SIZE_BITS-1:0]  rowSize,
  input  logic [`DATA_BITS-1:0]  opIn,
  output logic [`SIZE_BITS-1:0]  matchPos,
  output logic [`SIZE_BITS-1:0]  lessCount,
  output logic [`SIZE_BITS-1:0]  greaterCount
);

  // Scan the live part of the row only
  always_comb begin
    logic [`DATA_BITS-1:0] elem;

    matchPos     = '0;
    lessCount    = '0;
    greaterCount = '0;
    elem         = '0;
    for (int i = 0; i < `INDEX_MAX; i++) begin
      elem = rowData[i*`DATA_BITS +: `DATA_BITS];
      if (i < int'(rowSize)) begin
        if (elem == opIn) begin
          matchPos = `SIZE_BITS'(i + 1);              // Later hits win
        end
        if (elem < opIn) begin
          lessCount = lessCount + 1'b1;
        end
        if (elem > opIn) begin
          greaterCount = greaterCount + 1'b1;
        end
      end
    end
  end

endmodule

/* verilog/arrayStore.sv */
`timescale 1ns/100ps
`include "arrayMemory_defines.svh"

module arrayStore import arrayPkg::*; (
  input  logic                    clock,
  input  logic                    rstN,
  input  arrayAction_t            opCode,
  input  logic [`ARRAY_BITS-1:0]  opArray,
  input  logic [`INDEX_BITS-1:0]  opIndex,
  input  logic [`DATA_BITS-1:0]   opIn,
  input  logic [`ARRAY_BITS-1:0]  longArray,
  input  logic [`INDEX_BITS-1:0]  longIndex,
  output logic [`ROW_BITS-1:0]    rowData,
  output logic [`SIZE_BITS-1:0]   rowSize,
  output logic                    popHit
);

  logic [`DATA_BITS-1:0]  mem [`ARRAY_COUNT][`INDEX_MAX];   // Element memory
  logic [`SIZE_BITS-1:0]  sizeTable [`ARRAY_COUNT];         // Current size per array
  logic [`INDEX_MAX-1:0]  longHit;                          // Long2 copies offset i
  logic [`SIZE_BITS-1:0]  longEnd;                          // Target size after long2
  logic                   rowFull;
  logic [`INDEX_BITS-1:0] pushIndex;

  // Selected row, read combinationally
  always_comb begin
    for (int i = 0; i < `INDEX_MAX; i++) begin
      rowData[i*`DATA_BITS +: `DATA_BITS] = mem[opArray][i];
    end
  end

  assign rowSize   = sizeTable[opArray];
  assign rowFull   = (rowSize == `INDEX_MAX);
  assign popHit    = (opCode == actPop) && (rowSize != '0);
  assign pushIndex = rowSize[`INDEX_BITS-1:0];              // Only used when not full

  // Long move extent, stopping at either array end
  always_comb begin
    longEnd = rowSize;
    for (int i = 0; i < `INDEX_MAX; i++) begin
      longHit[i] = (i < int'(opIn))
                && (int'(opIndex) + i < `INDEX_MAX)
                && (int'(longIndex) + i < `INDEX_MAX);
      if (longHit[i] && (int'(opIndex) + i >= int'(longEnd))) begin
        longEnd = `SIZE_BITS'(int'(opIndex) + i + 1);
      end
    end
  end

  // Element updates; right-hand reads see the memory before this edge
  always_ff @(posedge clock) begin
    case (opCode)
      actWrite: begin
        mem[opArray][opIndex] <= opIn;
      end
      actUp: begin
        for (int i = 1; i < `INDEX_MAX; i++) begin
          if (i > int'(opIndex) && i <= int'(rowSize)) begin
            mem[opArray][i] <= mem[opArray][i-1];       // Top drops out when full
          end
        end
        mem[opArray][opIndex] <= opIn;
      end
      actLong2: begin
        for (int i = 0; i < `INDEX_MAX; i++) begin
          if (longHit[i]) begin
            mem[opArray][`INDEX_BITS'(int'(opIndex) + i)] <=
              mem[longArray][`INDEX_BITS'(int'(longIndex) + i)];
          end
        end
      end
      actPush: begin
        if (!rowFull) begin
          mem[opArray][pushIndex] <= opIn;
        end
      end
      default: ;
    endcase
  end

  // Size table
  always_ff @(posedge clock) begin
    if (!rstN) begin
      for (int a = 0; a < `ARRAY_COUNT; a++) begin
        sizeTable[a] <= '0;
      end
    end else begin
      case (opCode)
        actReset: begin
          for (int a = 0; a < `ARRAY_COUNT; a++) begin
            sizeTable[a] <= '0;
          end
        end
        actWrite: begin
          if ({1'b0, opIndex} >= rowSize) begin
            sizeTable[opArray] <= {1'b0, opIndex} + 1'b1;  // Extend to cover index
          end
        end
        actInc, actUp, actPush: begin
          if (!rowFull) begin
            sizeTable[opArray] <= rowSize + 1'b1;
          end
        end
        actDec, actPop: begin
          if (rowSize != '0) begin
            sizeTable[opArray] <= rowSize - 1'b1;
          end
        end
        actLong2: begin
          sizeTable[opArray] <= longEnd;
        end
        default: ;
      endcase
    end
  end

endmodule

/* verilog/actionDecode.sv */
`timescale 1ns/100ps
`include "arrayMemory_defines.svh"

module actionDecode import arrayPkg::*; (
  input  logic                    clock,
  input  logic                    rstN,
  input  arrayAction_t            action,
  input  logic [`ARRAY_BITS-1:0]  array,
  input  logic [`INDEX_BITS-1:0]  index,
  input  logic [`DATA_BITS-1:0]   in,
  output arrayAction_t            opCode,
  output logic [`ARRAY_BITS-1:0]  opArray,
  output logic [`INDEX_BITS-1:0]  opIndex,
  output logic [`DATA_BITS-1:0]   opIn,
  output logic [`ARRAY_BITS-1:0]  longArray,
  output logic [`INDEX_BITS-1:0]  longIndex
);

  arrayAction_t nextCode;

  always_comb begin
    case (action)
      actReset, actWrite, actRead, actSize, actInc, actDec,
      actIndex, actLess, actGreater, actUp, actLong1, actLong2,
      actPush, actPop: nextCode = action;
      default:         nextCode = actNone;           // Down, dump and unknown codes
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rstN) begin
      opCode    <= actNone;
      longArray <= '0;
      longIndex <= '0;
    end else begin
      opCode <= nextCode;
      if (action == actLong1) begin                  // Held until the next long1
        longArray <= array;
        longIndex <= index;
      end
    end
  end

  always_ff @(posedge clock) begin
    opArray <= array;
    opIndex <= index;
    opIn    <= in;
  end

endmodule

/* verilog/arrayPkg.sv */
package arrayPkg;

  // Request codes sampled on the action port every clock
  typedef enum logic [7:0] {
    actNone    = 8'd0,                              // Idle
    actReset   = 8'd1,                              // Zero every size
    actWrite   = 8'd2,
    actRead    = 8'd3,
    actSize    = 8'd4,
    actInc     = 8'd5,                              // Saturates at INDEX_MAX
    actDec     = 8'd6,                              // Saturates at zero
    actIndex   = 8'd7,                              // Last match position plus one
    actLess    = 8'd8,
    actGreater = 8'd9,
    actUp      = 8'd10,                             // Insert with shift up
    actDown    = 8'd11,                             // Not implemented
    actLong1   = 8'd12,                             // Long move source
    actLong2   = 8'd13,                             // Long move target and count
    actPush    = 8'd14,
    actPop     = 8'd15,
    actDump    = 8'd16                              // Not implemented
  } arrayAction_t;

endpackage

/* verilog/arrayMemory_defines.svh */
`ifndef ARRAY_MEMORY_DEFINES_SVH
`define ARRAY_MEMORY_DEFINES_SVH

// Store geometry
`define ARRAY_COUNT 4                               // Number of arrays
`define ARRAY_BITS  2                               // Width of an array number
`define INDEX_BITS  3                               // Width of an element index
`define DATA_BITS   16                              // Element and result width

// Derived sizes
`define INDEX_MAX   (1 << `INDEX_BITS)              // Elements per array
`define SIZE_BITS   (`INDEX_BITS + 1)               // Size runs 0 to INDEX_MAX inclusive
`define ROW_BITS    (`INDEX_MAX * `DATA_BITS)       // One array row, packed

`endif
